// ==== filelist.f ====
hw/blit_pkg.sv
hw/rect_walker.sv
hw/texel_address.sv
hw/texel_fetch.sv
hw/pixel_writer.sv
hw/blitter_top.sv
testbench/blit_mem_model.sv
testbench/blitter_tb.sv

// ==== hw/blit_pkg.sv ====
package blit_pkg;

    // numeric value is the depth in bits
    typedef enum logic [4:0] {
        BPP_1  = 5'd1,
        BPP_2  = 5'd2,
        BPP_4  = 5'd4,
        BPP_8  = 5'd8,
        BPP_16 = 5'd16
    } bpp_e;

    typedef enum logic {
        FETCHED = 1'b0, // memory or colour table result
        SOLID   = 1'b1  // command draw colour
    } colour_src_e;

    typedef struct packed {
        logic [31:0] image_start;
        logic [15:0] image_width;
        logic [15:0] src_x;
        logic [15:0] src_y;
        logic [15:0] width;
        logic [15:0] height;
        logic [15:0] screen_x;
        logic [15:0] screen_y;
        logic        mirror_x;
        logic        mirror_y;
        bpp_e        bpp;
        logic        ct_enable;
        logic [15:0] ct_offset;
        colour_src_e colour_src;
        logic [15:0] draw_colour;
    } draw_cmd_t;

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
    } screen_pos_t;

    typedef struct packed {
        screen_pos_t pos;
        logic [31:0] src_index; // pixel index inside the image
    } walk_item_t;

    typedef struct packed {
        screen_pos_t pos;
        logic [31:0] word_addr;
        logic [4:0]  bit_offset; // counted from the msb
    } fetch_req_t;

    typedef struct packed {
        screen_pos_t pos;
        logic [15:0] value; // colour or table index
    } texel_t;

    typedef struct packed {
        screen_pos_t pos;
        logic [15:0] colour;
    } fb_write_t;

endpackage

// ==== hw/blitter_top.sv ====
module blitter_top #(
    parameter int unsigned FB_WIDTH  = 400,
    parameter int unsigned FB_HEIGHT = 240
) (
    input  logic                  clk,
    input  logic                  rst,
    input  blit_pkg::draw_cmd_t   cmd,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    output logic                  busy,
    output logic [31:0]           m_axil_araddr,
    output logic                  m_axil_arvalid,
    input  logic                  m_axil_arready,
    input  logic [31:0]           m_axil_rdata,
    input  logic                  m_axil_rvalid,
    output logic                  m_axil_rready,
    output logic [15:0]           ct_address,
    input  logic [15:0]           ct_colour,
    output blit_pkg::fb_write_t   fb,
    output logic                  fb_write
);

    import blit_pkg::*;

    walk_item_t walk_item;
    logic       walk_valid, walk_ready, walk_busy, walk_cmd_ready;
    fetch_req_t fetch_req;
    logic       req_valid, req_ready, addr_busy;
    texel_t     texel;
    logic       texel_valid, texel_ready, fetch_busy;
    logic       writer_busy;
    logic       pipe_busy;

    // new command only once everything behind the walker has drained
    assign pipe_busy = addr_busy || fetch_busy || writer_busy;
    assign cmd_ready = walk_cmd_ready && !pipe_busy;
    assign busy      = walk_busy || pipe_busy;

    rect_walker #(
        .FB_WIDTH (FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT)
    ) walker_i (
        .clk(clk), .rst(rst),
        .cmd(cmd), .cmd_valid(cmd_valid && !pipe_busy), .cmd_ready(walk_cmd_ready),
        .item(walk_item), .item_valid(walk_valid), .item_ready(walk_ready),
        .busy(walk_busy)
    );

    texel_address address_i (
        .clk(clk), .rst(rst),
        .image_start(cmd.image_start), .bpp(cmd.bpp),
        .in_item(walk_item), .in_valid(walk_valid), .in_ready(walk_ready),
        .req(fetch_req), .req_valid(req_valid), .req_ready(req_ready),
        .busy(addr_busy)
    );

    texel_fetch fetch_i (
        .clk(clk), .rst(rst), .bpp(cmd.bpp),
        .req(fetch_req), .req_valid(req_valid), .req_ready(req_ready),
        .araddr(m_axil_araddr), .arvalid(m_axil_arvalid), .arready(m_axil_arready),
        .rdata(m_axil_rdata), .rvalid(m_axil_rvalid), .rready(m_axil_rready),
        .texel(texel), .texel_valid(texel_valid), .texel_ready(texel_ready),
        .busy(fetch_busy)
    );

    pixel_writer writer_i (
        .clk(clk), .rst(rst),
        .ct_enable(cmd.ct_enable), .ct_offset(cmd.ct_offset),
        .colour_src(cmd.colour_src), .draw_colour(cmd.draw_colour),
        .texel(texel), .texel_valid(texel_valid), .texel_ready(texel_ready),
        .ct_address(ct_address), .ct_colour(ct_colour),
        .fb(fb), .fb_write(fb_write), .busy(writer_busy)
    );

endmodule

// ==== hw/pixel_writer.sv ====
module pixel_writer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ct_enable,
    input  logic [15:0]             ct_offset,
    input  blit_pkg::colour_src_e   colour_src,
    input  logic [15:0]             draw_colour,
    input  blit_pkg::texel_t        texel,
    input  logic                    texel_valid,
    output logic                    texel_ready,
    output logic [15:0]             ct_address,
    input  logic [15:0]             ct_colour,
    output blit_pkg::fb_write_t     fb,
    output logic                    fb_write,
    output logic                    busy
);

    import blit_pkg::*;

    screen_pos_t ct_pos;   // position waiting on the table read
    logic        ct_valid;
    logic        texel_xfer;
    logic        load_fb;
    logic [15:0] fetched;

    assign texel_ready = 1'b1; // no back-pressure from the framebuffer
    assign texel_xfer  = texel_valid && texel_ready;

    // table samples the address on the transfer edge
    assign ct_address = texel.value + ct_offset;

    assign load_fb = ct_enable ? ct_valid : texel_xfer;
    assign fetched = ct_enable ? ct_colour : texel.value;
    assign busy    = ct_valid || fb_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            ct_valid <= 1'b0;
            fb_write <= 1'b0;
        end else begin
            ct_valid <= texel_xfer && ct_enable;
            fb_write <= load_fb;
        end
    end

    always_ff @(posedge clk) begin
        if (texel_xfer) begin
            ct_pos <= texel.pos;
        end
        if (load_fb) begin
            fb.pos    <= ct_enable ? ct_pos : texel.pos;
            fb.colour <= (colour_src == SOLID) ? draw_colour : fetched;
        end
    end

endmodule

// ==== hw/rect_walker.sv ====
module rect_walker #(
    parameter int unsigned FB_WIDTH  = 400,
    parameter int unsigned FB_HEIGHT = 240
) (
    input  logic                   clk,
    input  logic                   rst,
    input  blit_pkg::draw_cmd_t    cmd,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    output blit_pkg::walk_item_t   item,
    output logic                   item_valid,
    input  logic                   item_ready,
    output logic                   busy
);

    logic        active;
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] last_x;
    logic [15:0] last_y;
    logic [15:0] scr_x;
    logic [15:0] scr_y;
    logic [31:0] src_col;
    logic [31:0] src_row;
    logic        on_screen;
    logic        advance;

    // command fields stay stable while busy
    assign last_x = cmd.width - 16'd1;
    assign last_y = cmd.height - 16'd1;

    assign scr_x = cmd.screen_x + (cmd.mirror_x ? last_x - x : x);
    assign scr_y = cmd.screen_y + (cmd.mirror_y ? last_y - y : y);

    assign src_col = {16'd0, cmd.src_x} + {16'd0, x};
    assign src_row = {16'd0, cmd.src_y} + {16'd0, y};

    assign on_screen = (32'(scr_x) < FB_WIDTH) && (32'(scr_y) < FB_HEIGHT);

    assign item.pos.x     = scr_x;
    assign item.pos.y     = scr_y;
    assign item.src_index = src_col + src_row * {16'd0, cmd.image_width};
    assign item_valid     = active && on_screen;

    // clipped positions step on without a handshake
    assign advance = active && (!on_screen || item_ready);
    assign busy    = active;

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            cmd_ready <= 1'b0;
            x         <= 16'd0;
            y         <= 16'd0;
        end else if (!active) begin
            cmd_ready <= 1'b1;
            if (cmd_valid && cmd_ready) begin
                x <= 16'd0;
                y <= 16'd0;
                // empty rectangle finishes right here
                if (cmd.width != 16'd0 && cmd.height != 16'd0) begin
                    active    <= 1'b1;
                    cmd_ready <= 1'b0;
                end
            end
        end else if (advance) begin
            if (x == last_x) begin
                x <= 16'd0;
                if (y == last_y) begin
                    active    <= 1'b0;
                    cmd_ready <= 1'b1;
                end else begin
                    y <= y + 16'd1;
                end
            end else begin
                x <= x + 16'd1;
            end
        end
    end

endmodule

// ==== hw/texel_address.sv ====
module texel_address (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [31:0]            image_start,
    input  blit_pkg::bpp_e         bpp,
    input  blit_pkg::walk_item_t   in_item,
    input  logic                   in_valid,
    output logic                   in_ready,
    output blit_pkg::fetch_req_t   req,
    output logic                   req_valid,
    input  logic                   req_ready,
    output logic                   busy
);

    import blit_pkg::*;

    typedef enum logic [1:0] {
        S_EMPTY,
        S_FULL,
        S_BUF_FULL
    } state_e;

    state_e      state;
    fetch_req_t  next_req;
    fetch_req_t  skid; // second entry under back-pressure
    logic [31:0] bit_addr;
    logic [31:0] byte_addr;
    logic        in_xfer;
    logic        out_xfer;

    assign bit_addr  = in_item.src_index * {27'd0, bpp};
    assign byte_addr = image_start + {3'd0, bit_addr[31:3]};

    assign next_req.pos        = in_item.pos;
    assign next_req.word_addr  = {byte_addr[31:2], 2'b00};
    assign next_req.bit_offset = bit_addr[4:0];

    assign in_ready  = (state != S_BUF_FULL);
    assign req_valid = (state != S_EMPTY);
    assign busy      = (state != S_EMPTY);
    assign in_xfer   = in_valid && in_ready;
    assign out_xfer  = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_EMPTY;
        end else begin
            case (state)
                S_EMPTY: begin
                    if (in_xfer) begin
                        req   <= next_req;
                        state <= S_FULL;
                    end
                end
                S_FULL: begin
                    if (in_xfer && !out_xfer) begin
                        skid  <= next_req; // output holds, park the new one
                        state <= S_BUF_FULL;
                    end else if (in_xfer) begin
                        req <= next_req;
                    end else if (out_xfer) begin
                        state <= S_EMPTY;
                    end
                end
                S_BUF_FULL: begin
                    if (out_xfer) begin
                        req   <= skid;
                        state <= S_FULL;
                    end
                end
                default: state <= S_EMPTY;
            endcase
        end
    end

endmodule

// ==== hw/texel_fetch.sv ====
module texel_fetch (
    input  logic                   clk,
    input  logic                   rst,
    input  blit_pkg::bpp_e         bpp,
    input  blit_pkg::fetch_req_t   req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output logic [31:0]            araddr,
    output logic                   arvalid,
    input  logic                   arready,
    input  logic [31:0]            rdata,
    input  logic                   rvalid,
    output logic                   rready,
    output blit_pkg::texel_t       texel,
    output logic                   texel_valid,
    input  logic                   texel_ready,
    output logic                   busy
);

    import blit_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_READY
    } state_e;

    state_e      state;
    logic        cache_valid;
    logic [31:0] cache_addr;
    logic [31:0] cache_word;
    logic [4:0]  bit_offset;
    logic        req_xfer;
    logic        cache_hit;

    // texel sits offset bits below the msb, depth bits wide
    function automatic logic [15:0] extract(
        input logic [31:0] word,
        input logic [4:0]  offset,
        input bpp_e        depth
    );
        logic [5:0]  shift;
        logic [16:0] mask;
        shift = 6'd32 - {1'b0, offset} - {1'b0, depth};
        mask  = (17'd1 << depth) - 17'd1;
        return 16'(word >> shift) & mask[15:0];
    endfunction

    assign req_ready   = (state == S_IDLE);
    assign texel_valid = (state == S_READY);
    assign busy        = (state != S_IDLE);
    assign req_xfer    = req_valid && req_ready;
    assign cache_hit   = cache_valid && (cache_addr == req.word_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            arvalid     <= 1'b0;
            rready      <= 1'b0;
            cache_valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_xfer) begin
                        texel.pos  <= req.pos;
                        bit_offset <= req.bit_offset;
                        araddr     <= req.word_addr;
                        if (cache_hit) begin
                            texel.value <= extract(cache_word, req.bit_offset, bpp);
                            state       <= S_READY;
                        end else begin
                            arvalid <= 1'b1;
                            state   <= S_ADDR;
                        end
                    end
                end
                S_ADDR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (rvalid) begin
                        rready      <= 1'b0;
                        cache_word  <= rdata;
                        cache_addr  <= araddr;
                        cache_valid <= 1'b1;
                        texel.value <= extract(rdata, bit_offset, bpp);
                        state       <= S_READY;
                    end
                end
                S_READY: begin
                    if (texel_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the blitter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module blitter_tb \
    -f filelist.f

out=$(./obj_dir/Vblitter_tb)
echo "$out"

# a missing pass line makes grep fail, and set -e turns that into the exit status
echo "$out" | grep -qx '>>> PASS'

// ==== testbench/blit_mem_model.sv ====
module blit_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rvalid,
    input  logic        rready,
    input  logic [15:0] ct_address,
    output logic [15:0] ct_colour
);

    logic [31:0] lfsr;
    logic [31:0] addr_q;
    logic [1:0]  stall;      // cycles left before the next ready or valid
    logic        data_phase;

    // image content, every word a mix of its full address
    function automatic logic [31:0] image_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [15:0] table_colour(input logic [15:0] addr);
        return (addr * 16'h2f47) ^ 16'ha5c3;
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [1:0] stall_bits(input logic [31:0] s);
        logic [31:0] s1;
        logic [31:0] s2;
        s1 = lfsr_step(s);
        s2 = lfsr_step(s1);
        return {s1[0], s2[0]};
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr       <= 32'h9096;
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            data_phase <= 1'b0;
            stall      <= 2'd0;
        end else begin
            if (arvalid && arready) begin
                arready    <= 1'b0;
                addr_q     <= araddr;
                data_phase <= 1'b1;
                stall      <= stall_bits(lfsr);
                lfsr       <= lfsr_step(lfsr_step(lfsr));
            end else if (!data_phase && arvalid) begin
                if (stall == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    stall <= stall - 2'd1;
                end
            end
            if (rvalid && rready) begin
                rvalid     <= 1'b0;
                data_phase <= 1'b0;
                stall      <= stall_bits(lfsr);
                lfsr       <= lfsr_step(lfsr_step(lfsr));
            end else if (data_phase && !rvalid) begin
                if (stall == 2'd0) begin
                    rvalid <= 1'b1;
                    rdata  <= image_word(addr_q);
                end else begin
                    stall <= stall - 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        ct_colour <= table_colour(ct_address); // one cycle read
    end

endmodule

// ==== testbench/blitter_tb.sv ====
module blitter_tb;

    import blit_pkg::*;

    localparam int FB_W             = 32;
    localparam int FB_H             = 16;
    localparam int CYCLES_PER_PIXEL = 20; // miss with both channels fully stalled
    localparam int PIXEL_BUDGET     = 24 + 15 + 48 + 32 + 30;
    localparam int WATCHDOG_CYCLES  = PIXEL_BUDGET * CYCLES_PER_PIXEL + 400;

    logic        clk;
    logic        rst;
    draw_cmd_t   cmd;
    logic        cmd_valid;
    logic        cmd_ready;
    logic        busy;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
    logic        rready;
    logic [15:0] ct_address;
    logic [15:0] ct_colour;
    fb_write_t   fb;
    logic        fb_write;

    fb_write_t   exp_q[$];
    logic [31:0] exp_ar_q[$]; // word addresses of the expected bus reads
    int          errors;
    int          writes;
    int          ar_count;
    int          tests_run;
    int          tests_failed;
    int          err_start;
    bit          quick_idle;
    bit          idle_due;
    logic [31:0] model_cache_addr; // word the fetch stage should be holding
    bit          model_cache_valid;
    draw_cmd_t   c;

    blitter_top #(.FB_WIDTH(FB_W), .FB_HEIGHT(FB_H)) dut_i (
        .clk(clk), .rst(rst),
        .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .busy(busy),
        .m_axil_araddr(araddr), .m_axil_arvalid(arvalid), .m_axil_arready(arready),
        .m_axil_rdata(rdata), .m_axil_rvalid(rvalid), .m_axil_rready(rready),
        .ct_address(ct_address), .ct_colour(ct_colour),
        .fb(fb), .fb_write(fb_write)
    );

    blit_mem_model mem_i (
        .clk(clk), .rst(rst),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .ct_address(ct_address), .ct_colour(ct_colour)
    );

    function automatic logic [31:0] image_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [15:0] table_colour(input logic [15:0] addr);
        return (addr * 16'h2f47) ^ 16'ha5c3;
    endfunction

    // shift the texel up to the msb, then take its top bits
    function automatic logic [15:0] texel_of(input logic [31:0] word, input int off,
                                             input int depth);
        logic [31:0] aligned;
        aligned = word << off;
        return 16'(aligned >> (32 - depth));
    endfunction

    function automatic draw_cmd_t rect_cmd(
        input logic [31:0] start, input logic [15:0] img_w, input bpp_e depth,
        input logic [15:0] sx0, input logic [15:0] sy0,
        input logic [15:0] w, input logic [15:0] h,
        input logic [15:0] dx, input logic [15:0] dy
    );
        draw_cmd_t r;
        r = '0;
        r.image_start = start;
        r.image_width = img_w;
        r.bpp         = depth;
        r.src_x       = sx0;
        r.src_y       = sy0;
        r.width       = w;
        r.height      = h;
        r.screen_x    = dx;
        r.screen_y    = dy;
        return r;
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("** Error at time %0t: %s is %h, expected %h", $time, sig, got, expected);
        errors++;
    endtask

    // walk order reference with the bus reads that a one-word cache needs
    task automatic build_expected(input draw_cmd_t d, output int reads);
        logic [15:0] sx;
        logic [15:0] sy;
        logic [31:0] index;
        logic [31:0] bit_addr;
        logic [31:0] word_addr;
        logic [15:0] tex;
        fb_write_t   px;
        int          depth;
        reads = 0;
        depth = int'(d.bpp);
        for (int y = 0; y < int'(d.height); y++) begin
            for (int x = 0; x < int'(d.width); x++) begin
                sx = d.screen_x + 16'(d.mirror_x ? int'(d.width) - 1 - x : x);
                sy = d.screen_y + 16'(d.mirror_y ? int'(d.height) - 1 - y : y);
                if (int'(sx) < FB_W && int'(sy) < FB_H) begin
                    index = 32'(int'(d.src_x) + x)
                          + 32'(int'(d.src_y) + y) * {16'd0, d.image_width};
                    bit_addr  = index * 32'(depth);
                    word_addr = (d.image_start + (bit_addr >> 3)) & 32'hffff_fffc;
                    if (!model_cache_valid || word_addr != model_cache_addr) begin
                        reads++;
                        exp_ar_q.push_back(word_addr);
                        model_cache_addr  = word_addr;
                        model_cache_valid = 1'b1;
                    end
                    tex = texel_of(image_word(word_addr), int'(bit_addr[4:0]), depth);
                    px.pos.x = sx;
                    px.pos.y = sy;
                    if (d.colour_src == SOLID) begin
                        px.colour = d.draw_colour;
                    end else if (d.ct_enable) begin
                        px.colour = table_colour(tex + d.ct_offset);
                    end else begin
                        px.colour = tex;
                    end
                    exp_q.push_back(px);
                end
            end
        end
    endtask

    task automatic close_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - err_before);
        end
    endtask

    task automatic run_test(input string name, input draw_cmd_t d, input bit idle_check);
        int err_before;
        int reads;
        int exp_count;
        int ar_before;
        int limit;
        int n;
        err_before = errors;
        exp_ar_q.delete();
        build_expected(d, reads);
        exp_count  = exp_q.size();
        quick_idle = idle_check;
        writes     = 0;
        ar_before  = ar_count;
        limit      = int'(d.width) * int'(d.height) * CYCLES_PER_PIXEL + 50;
        n = 0;
        while (!cmd_ready && n < 50) begin
            @(posedge clk);
            #1;
            n++;
        end
        assert (cmd_ready) else begin
            $display("cmd_ready stayed low before test %s", name);
            errors++;
        end
        cmd       = d;
        cmd_valid = 1'b1;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        n = 0;
        while ((busy || exp_q.size() != 0) && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (n >= limit) begin
            $display("test %s did not finish within %0d cycles", name, limit);
            errors++;
            exp_q.delete();
        end
        repeat (3) @(posedge clk); // room for stray writes
        #1;
        assert (writes == exp_count)
            else report_mismatch("fb_write count", 32'(writes), 32'(exp_count));
        assert (ar_count - ar_before == reads)
            else report_mismatch("ar handshakes", 32'(ar_count - ar_before), 32'(reads));
        close_test(name, err_before);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(4 * WATCHDOG_CYCLES);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    always @(negedge clk) begin : check_outputs
        fb_write_t   head;
        logic [31:0] exp_addr;
        if (rst) begin
            assert (!busy) else report_mismatch("busy", 32'(busy), 32'd0);
            assert (!arvalid) else report_mismatch("m_axil_arvalid", 32'(arvalid), 32'd0);
            assert (!rready) else report_mismatch("m_axil_rready", 32'(rready), 32'd0);
            assert (!fb_write) else report_mismatch("fb_write", 32'(fb_write), 32'd0);
        end else begin
            if (idle_due) begin
                assert (!busy) else report_mismatch("busy", 32'(busy), 32'd0);
                idle_due = 1'b0;
            end
            if (arvalid && arready) begin
                ar_count++;
                if (exp_ar_q.size() != 0) begin
                    exp_addr = exp_ar_q.pop_front();
                    assert (araddr == exp_addr)
                        else report_mismatch("m_axil_araddr", araddr, exp_addr);
                end
            end
            if (fb_write) begin
                writes++;
                assert (exp_q.size() != 0) else begin
                    $display("framebuffer write at time %0t with no pixel left", $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    head = exp_q.pop_front();
                    assert (fb.pos.x == head.pos.x)
                        else report_mismatch("fb.pos.x", 32'(fb.pos.x), 32'(head.pos.x));
                    assert (fb.pos.y == head.pos.y)
                        else report_mismatch("fb.pos.y", 32'(fb.pos.y), 32'(head.pos.y));
                    assert (fb.colour == head.colour)
                        else report_mismatch("fb.colour", 32'(fb.colour), 32'(head.colour));
                    if (exp_q.size() == 0 && quick_idle) idle_due = 1'b1;
                end
            end
        end
    end

    initial begin
        rst               = 1'b1;
        cmd               = '0;
        cmd_valid         = 1'b0;
        errors            = 0;
        writes            = 0;
        ar_count          = 0;
        tests_run         = 0;
        tests_failed      = 0;
        quick_idle        = 1'b0;
        idle_due          = 1'b0;
        model_cache_valid = 1'b0;
        model_cache_addr  = '0;
        err_start         = errors;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (4) begin
            if (!cmd_ready) begin
                @(posedge clk);
                #1;
            end
        end
        assert (cmd_ready) else begin
            $display("cmd_ready did not rise within 4 cycles of reset release");
            errors++;
        end
        close_test("reset", err_start);

        c = rect_cmd(32'h0000_1000, 16'd20, BPP_16, 16'd2, 16'd3, 16'd6, 16'd4, 16'd5, 16'd2);
        run_test("16 bpp direct", c, 1'b1);

        c = rect_cmd(32'h0000_2000, 16'd16, BPP_8, 16'd1, 16'd1, 16'd5, 16'd3, 16'd10, 16'd8);
        c.mirror_x = 1'b1;
        c.mirror_y = 1'b1;
        run_test("mirror x and y", c, 1'b1);

        // overlaps the right and bottom edges
        c = rect_cmd(32'h0000_3004, 16'd40, BPP_2, 16'd3, 16'd0, 16'd8, 16'd6, 16'd28, 16'd13);
        run_test("clipping", c, 1'b0);

        c = rect_cmd(32'h0000_4000, 16'd24, BPP_4, 16'd5, 16'd2, 16'd8, 16'd4, 16'd0, 16'd0);
        c.ct_enable = 1'b1;
        c.ct_offset = 16'h0100;
        run_test("4 bpp colour table", c, 1'b1);

        c = rect_cmd(32'h0000_5000, 16'd12, BPP_1, 16'd0, 16'd0, 16'd10, 16'd3, 16'd20, 16'd4);
        c.colour_src  = SOLID;
        c.draw_colour = 16'hbeef;
        run_test("solid colour", c, 1'b1);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
